// File: src/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

////////////////////////////////////////////////////////////
// core sizing
////////////////////////////////////////////////////////////

// architectural registers
`define OOO_NUM_REGS 8

// rename tags, one rename buffer entry per tag
`define OOO_NUM_TAGS 8

// reservation station entries
`define OOO_RS_DEPTH 8

// reorder buffer entries, kept a power of two for pointer wrap
`define OOO_ROB_DEPTH 16

// register and result width
`define OOO_DATA_W 16

`endif

// File: src/ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;

	// one register value
	typedef logic [`OOO_DATA_W-1:0] data_t;

	// architectural register number
	typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;

	// rename tag
	typedef logic [$clog2(`OOO_NUM_TAGS)-1:0] tag_t;

	// integer opcodes
	typedef enum logic [3:0]
	{
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_addi = 4'd5,
		op_li   = 4'd6
	} opcode_e;

endpackage

// File: src/rename_unit.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module rename_unit
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              dispatch,
	input  ooo_pkg::opcode_e  op,
	input  ooo_pkg::reg_idx_t rs1,
	input  ooo_pkg::reg_idx_t rs2,
	input  ooo_pkg::reg_idx_t rd,
	output logic              src1_ready,
	output logic              src2_ready,
	output ooo_pkg::data_t    src1_val,
	output ooo_pkg::data_t    src2_val,
	output ooo_pkg::tag_t     src1_tag,
	output ooo_pkg::tag_t     src2_tag,
	output ooo_pkg::tag_t     dest_tag,
	output logic              tags_empty,
	input  logic              bc_valid,
	input  ooo_pkg::tag_t     bc_tag,
	input  ooo_pkg::data_t    bc_result,
	input  logic              commit,
	input  ooo_pkg::tag_t     commit_tag,
	input  ooo_pkg::reg_idx_t commit_rd,
	output ooo_pkg::data_t    commit_data
);
	import ooo_pkg::*;

	localparam int NUM_REGS = `OOO_NUM_REGS;
	localparam int NUM_TAGS = `OOO_NUM_TAGS;

	// architectural file and rename table
	data_t               arf_data [NUM_REGS];
	logic [NUM_REGS-1:0] renamed;
	tag_t                arf_tag [NUM_REGS];

	// rename buffer and free list
	data_t               rrf_data [NUM_TAGS];
	logic [NUM_TAGS-1:0] rrf_valid;
	logic [NUM_TAGS-1:0] tag_free;

	////////////////////////////////////////////////////////////
	// operand read
	////////////////////////////////////////////////////////////

	// arf, then rename buffer, then this cycle's broadcast, else wait
	function automatic void read_src(input reg_idx_t idx, output logic rdy,
		output data_t val, output tag_t tag);
		tag_t t;
		t   = arf_tag[idx];
		rdy = 1'b1;
		val = '0;
		tag = '0;
		if (!renamed[idx])
			val = arf_data[idx];
		else if (rrf_valid[t])
			val = rrf_data[t];
		else if (bc_valid && bc_tag == t)
			val = bc_result;
		else
		begin
			rdy = 1'b0;
			tag = t;
		end
	endfunction

	always_comb
	begin
		read_src(rs1, src1_ready, src1_val, src1_tag);
		read_src(rs2, src2_ready, src2_val, src2_tag);
		// li has no sources, addi only rs1
		if (op == op_li)
		begin
			src1_ready = 1'b1;
			src1_val   = '0;
			src1_tag   = '0;
		end
		if (op == op_li || op == op_addi)
		begin
			src2_ready = 1'b1;
			src2_val   = '0;
			src2_tag   = '0;
		end
	end

	// lowest free tag first
	always_comb
	begin
		dest_tag = '0;
		for (int i = NUM_TAGS - 1; i >= 0; i--)
		begin
			if (tag_free[i])
				dest_tag = tag_t'(i);
		end
	end

	assign tags_empty  = ~|tag_free;
	assign commit_data = rrf_data[commit_tag];

	////////////////////////////////////////////////////////////
	// table updates
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				arf_data[i] <= data_t'(i);
			renamed   <= '0;
			rrf_valid <= '0;
			tag_free  <= '1;
		end
		else
		begin
			if (bc_valid)
				rrf_valid[bc_tag] <= 1'b1;
			// retire into the arf and release the tag
			if (commit)
			begin
				arf_data[commit_rd]   <= commit_data;
				rrf_valid[commit_tag] <= 1'b0;
				tag_free[commit_tag]  <= 1'b1;
				if (arf_tag[commit_rd] == commit_tag)
					renamed[commit_rd] <= 1'b0;
			end
			// newer mapping wins over an unrename of the same rd
			if (dispatch)
			begin
				renamed[rd]        <= 1'b1;
				tag_free[dest_tag] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (bc_valid)
			rrf_data[bc_tag] <= bc_result;
		if (dispatch)
			arf_tag[rd] <= dest_tag;
	end

endmodule

// File: src/reservation_station.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module reservation_station
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             dispatch,
	input  ooo_pkg::opcode_e op,
	input  ooo_pkg::data_t   imm,
	input  logic             src1_ready,
	input  ooo_pkg::data_t   src1_val,
	input  ooo_pkg::tag_t    src1_tag,
	input  logic             src2_ready,
	input  ooo_pkg::data_t   src2_val,
	input  ooo_pkg::tag_t    src2_tag,
	input  ooo_pkg::tag_t    dest_tag,
	output logic             full,
	input  logic             bc_valid,
	input  ooo_pkg::tag_t    bc_tag,
	input  ooo_pkg::data_t   bc_result,
	output logic             grant,
	output ooo_pkg::opcode_e grant_op,
	output ooo_pkg::data_t   grant_a,
	output ooo_pkg::data_t   grant_b,
	output ooo_pkg::data_t   grant_imm,
	output ooo_pkg::tag_t    grant_tag
);
	import ooo_pkg::*;

	localparam int DEPTH = `OOO_RS_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	// entry control
	logic [DEPTH-1:0] busy;
	logic [DEPTH-1:0] rdy_a;
	logic [DEPTH-1:0] rdy_b;
	// number of younger entries still waiting, the oldest has the largest
	logic [IDX_W-1:0] age [DEPTH];

	// entry payload
	opcode_e ent_op [DEPTH];
	data_t   ent_a [DEPTH];
	data_t   ent_b [DEPTH];
	data_t   ent_imm [DEPTH];
	tag_t    ent_tag_a [DEPTH];
	tag_t    ent_tag_b [DEPTH];
	tag_t    ent_dest [DEPTH];

	logic [DEPTH-1:0] ready;
	logic [DEPTH-1:0] wake_a;
	logic [DEPTH-1:0] wake_b;
	logic [IDX_W-1:0] alloc_idx;
	logic [IDX_W-1:0] sel_idx;

	assign full  = &busy;
	assign ready = busy & rdy_a & rdy_b;

	// tag match against the broadcast
	always_comb
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			wake_a[i] = busy[i] && !rdy_a[i] && bc_valid && ent_tag_a[i] == bc_tag;
			wake_b[i] = busy[i] && !rdy_b[i] && bc_valid && ent_tag_b[i] == bc_tag;
		end
	end

	// lowest empty entry takes the new instruction
	always_comb
	begin
		alloc_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--)
		begin
			if (!busy[i])
				alloc_idx = IDX_W'(i);
		end
	end

	////////////////////////////////////////////////////////////
	// oldest-first select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		grant   = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < DEPTH; i++)
		begin
			if (ready[i] && (!grant || age[i] > age[sel_idx]))
			begin
				grant   = 1'b1;
				sel_idx = IDX_W'(i);
			end
		end
	end

	assign grant_op  = ent_op[sel_idx];
	assign grant_a   = ent_a[sel_idx];
	assign grant_b   = ent_b[sel_idx];
	assign grant_imm = ent_imm[sel_idx];
	assign grant_tag = ent_dest[sel_idx];

	////////////////////////////////////////////////////////////
	// entry state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy  <= '0;
			rdy_a <= '0;
			rdy_b <= '0;
			for (int i = 0; i < DEPTH; i++)
				age[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				if (wake_a[i])
					rdy_a[i] <= 1'b1;
				if (wake_b[i])
					rdy_b[i] <= 1'b1;
				// one more younger on dispatch, one fewer when a younger leaves
				if (busy[i])
					age[i] <= age[i] + IDX_W'(dispatch)
						- IDX_W'(grant && age[i] > age[sel_idx]);
			end
			if (grant)
				busy[sel_idx] <= 1'b0;
			if (dispatch)
			begin
				busy[alloc_idx]  <= 1'b1;
				rdy_a[alloc_idx] <= src1_ready;
				rdy_b[alloc_idx] <= src2_ready;
				age[alloc_idx]   <= '0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			if (wake_a[i])
				ent_a[i] <= bc_result;
			if (wake_b[i])
				ent_b[i] <= bc_result;
		end
		if (dispatch)
		begin
			ent_op[alloc_idx]    <= op;
			ent_a[alloc_idx]     <= src1_val;
			ent_b[alloc_idx]     <= src2_val;
			ent_tag_a[alloc_idx] <= src1_tag;
			ent_tag_b[alloc_idx] <= src2_tag;
			ent_imm[alloc_idx]   <= imm;
			ent_dest[alloc_idx]  <= dest_tag;
		end
	end

endmodule

// File: src/exec_unit.sv
`timescale 1ns/100ps

module exec_unit
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             grant,
	input  ooo_pkg::opcode_e grant_op,
	input  ooo_pkg::data_t   grant_a,
	input  ooo_pkg::data_t   grant_b,
	input  ooo_pkg::data_t   grant_imm,
	input  ooo_pkg::tag_t    grant_tag,
	output logic             bc_valid,
	output ooo_pkg::tag_t    bc_tag,
	output ooo_pkg::data_t   bc_result
);
	import ooo_pkg::*;

	data_t alu_result;

	// single ALU
	always_comb
	begin
		case (grant_op)
			op_add:  alu_result = grant_a + grant_b;
			op_sub:  alu_result = grant_a - grant_b;
			op_and:  alu_result = grant_a & grant_b;
			op_or:   alu_result = grant_a | grant_b;
			op_xor:  alu_result = grant_a ^ grant_b;
			op_addi: alu_result = grant_a + grant_imm;
			op_li:   alu_result = grant_imm;
			default: alu_result = '0;
		endcase
	end

	// broadcast one cycle after the grant
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bc_valid <= 1'b0;
		else
			bc_valid <= grant;
	end

	always_ff @(posedge clk)
	begin
		if (grant)
		begin
			bc_tag    <= grant_tag;
			bc_result <= alu_result;
		end
	end

endmodule

// File: src/reorder_buffer.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module reorder_buffer
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              dispatch,
	input  ooo_pkg::tag_t     dest_tag,
	input  ooo_pkg::reg_idx_t rd,
	output logic              full,
	input  logic              bc_valid,
	input  ooo_pkg::tag_t     bc_tag,
	output logic              commit,
	output ooo_pkg::tag_t     commit_tag,
	output ooo_pkg::reg_idx_t commit_rd
);
	import ooo_pkg::*;

	localparam int DEPTH = `OOO_ROB_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [DEPTH-1:0] busy;
	logic [DEPTH-1:0] finished;
	tag_t             ent_tag [DEPTH];
	reg_idx_t         ent_rd [DEPTH];

	// tail catching up with a busy head means no room
	assign full       = busy[tail];
	assign commit     = busy[head] & finished[head];
	assign commit_tag = ent_tag[head];
	assign commit_rd  = ent_rd[head];

	////////////////////////////////////////////////////////////
	// completion and retire
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			head     <= '0;
			tail     <= '0;
			busy     <= '0;
			finished <= '0;
		end
		else
		begin
			// tags are unique among busy entries
			for (int i = 0; i < DEPTH; i++)
			begin
				if (bc_valid && busy[i] && ent_tag[i] == bc_tag)
					finished[i] <= 1'b1;
			end
			if (commit)
			begin
				busy[head]     <= 1'b0;
				finished[head] <= 1'b0;
				head           <= head + 1'b1;
			end
			if (dispatch)
			begin
				busy[tail]     <= 1'b1;
				finished[tail] <= 1'b0;
				tail           <= tail + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (dispatch)
		begin
			ent_tag[tail] <= dest_tag;
			ent_rd[tail]  <= rd;
		end
	end

endmodule

// File: src/ooo_core.sv
`timescale 1ns/100ps

module ooo_core
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              issue,
	input  ooo_pkg::opcode_e  op,
	input  ooo_pkg::reg_idx_t rs1,
	input  ooo_pkg::reg_idx_t rs2,
	input  ooo_pkg::reg_idx_t rd,
	input  ooo_pkg::data_t    imm,
	output logic              dispatch_stall,
	output logic              commit_valid,
	output ooo_pkg::reg_idx_t commit_rd,
	output ooo_pkg::data_t    commit_data
);
	import ooo_pkg::*;

	logic    dispatch;
	logic    tags_empty;
	logic    rs_full;
	logic    rob_full;

	// renamed operands
	logic    src1_ready;
	logic    src2_ready;
	data_t   src1_val;
	data_t   src2_val;
	tag_t    src1_tag;
	tag_t    src2_tag;
	tag_t    dest_tag;

	// issue to the ALU
	logic    grant;
	opcode_e grant_op;
	data_t   grant_a;
	data_t   grant_b;
	data_t   grant_imm;
	tag_t    grant_tag;

	// result bus
	logic    bc_valid;
	tag_t    bc_tag;
	data_t   bc_result;

	tag_t    commit_tag;

	assign dispatch_stall = tags_empty | rs_full | rob_full;
	assign dispatch       = issue & ~dispatch_stall;

	rename_unit u_rename
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.dispatch    (dispatch),
		.op          (op),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd          (rd),
		.src1_ready  (src1_ready),
		.src2_ready  (src2_ready),
		.src1_val    (src1_val),
		.src2_val    (src2_val),
		.src1_tag    (src1_tag),
		.src2_tag    (src2_tag),
		.dest_tag    (dest_tag),
		.tags_empty  (tags_empty),
		.bc_valid    (bc_valid),
		.bc_tag      (bc_tag),
		.bc_result   (bc_result),
		.commit      (commit_valid),
		.commit_tag  (commit_tag),
		.commit_rd   (commit_rd),
		.commit_data (commit_data)
	);

	reservation_station u_rs
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.dispatch   (dispatch),
		.op         (op),
		.imm        (imm),
		.src1_ready (src1_ready),
		.src1_val   (src1_val),
		.src1_tag   (src1_tag),
		.src2_ready (src2_ready),
		.src2_val   (src2_val),
		.src2_tag   (src2_tag),
		.dest_tag   (dest_tag),
		.full       (rs_full),
		.bc_valid   (bc_valid),
		.bc_tag     (bc_tag),
		.bc_result  (bc_result),
		.grant      (grant),
		.grant_op   (grant_op),
		.grant_a    (grant_a),
		.grant_b    (grant_b),
		.grant_imm  (grant_imm),
		.grant_tag  (grant_tag)
	);

	exec_unit u_exec
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.grant     (grant),
		.grant_op  (grant_op),
		.grant_a   (grant_a),
		.grant_b   (grant_b),
		.grant_imm (grant_imm),
		.grant_tag (grant_tag),
		.bc_valid  (bc_valid),
		.bc_tag    (bc_tag),
		.bc_result (bc_result)
	);

	reorder_buffer u_rob
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.dispatch   (dispatch),
		.dest_tag   (dest_tag),
		.rd         (rd),
		.full       (rob_full),
		.bc_valid   (bc_valid),
		.bc_tag     (bc_tag),
		.commit     (commit_valid),
		.commit_tag (commit_tag),
		.commit_rd  (commit_rd)
	);

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

endmodule

// File: dv/ooo_monitor.sv
`timescale 1ns/100ps

module ooo_monitor
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              commit_valid,
	input  ooo_pkg::reg_idx_t commit_rd,
	input  ooo_pkg::data_t    commit_data,
	output logic              done,
	output int                error_count,
	output int                checked_count
);
	import ooo_pkg::*;

	localparam int MAX_INSTR = 64;
	localparam int FIELDS    = 6;

	logic [15:0] vec [MAX_INSTR*FIELDS];
	int          num_expected = 0;
	int          errors       = 0;
	int          checked      = 0;
	logic        all_seen     = 1'b0;

	assign done          = all_seen;
	assign error_count   = errors;
	assign checked_count = checked;

	// unused slots keep an op of ffff, which ends the program
	initial
	begin
		for (int i = 0; i < MAX_INSTR * FIELDS; i++)
			vec[i] = 16'hffff;
		$readmemh("dv/ooo_vectors.txt", vec);
		while (num_expected < MAX_INSTR && vec[num_expected*FIELDS] != 16'hffff)
			num_expected++;
	end

	////////////////////////////////////////////////////////////
	// in-order commit check
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		reg_idx_t exp_rd;
		data_t    exp_data;
		if (rst_n && commit_valid)
		begin
			if (checked >= num_expected)
			begin
				errors++;
				$display("%0t ns: unexpected commit to r%0d after the last instruction",
					$time, commit_rd);
			end
			else
			begin
				exp_rd   = reg_idx_t'(vec[checked*FIELDS+3]);
				exp_data = vec[checked*FIELDS+5];
				if (commit_rd !== exp_rd || commit_data !== exp_data)
				begin
					errors++;
					$display("[FAIL] %0t ns: commit %0d wrote r%0d = %h, expected r%0d = %h",
						$time, checked, commit_rd, commit_data, exp_rd, exp_data);
				end
				checked++;
				if (checked == num_expected)
					all_seen = 1'b1;
			end
		end
	end

endmodule

// File: dv/ooo_checker.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_checker
(
	input logic clk,
	input logic rst_n,
	input logic dispatch,
	input logic commit_valid,
	input logic dispatch_stall
);

	// accepted and not yet retired, each one holds a rename tag
	int in_flight;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			in_flight <= 0;
		else
			in_flight <= in_flight + int'(dispatch) - int'(commit_valid);
	end

	// nothing retires while reset is held
	commit_quiet_in_reset: assert property (@(posedge clk)
		(!rst_n && $past(!rst_n)) |-> !commit_valid)
		else $error("commit_valid high during reset");

	// retire only from an occupied head
	commit_from_busy_head: assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid |-> in_flight != 0)
		else $error("commit without a busy reorder buffer head");

	// every tag in use means the free list is empty
	stall_when_no_tags: assert property (@(posedge clk) disable iff (!rst_n)
		in_flight == `OOO_NUM_TAGS |-> dispatch_stall)
		else $error("free list empty but dispatch_stall low");

endmodule

bind ooo_core ooo_checker i_checker
(
	.clk            (clk),
	.rst_n          (rst_n),
	.dispatch       (dispatch),
	.commit_valid   (commit_valid),
	.dispatch_stall (dispatch_stall)
);

// File: dv/tb_ooo_core.sv
`timescale 1ns/100ps

module tb_ooo_core;
	import ooo_pkg::*;

	localparam int MAX_INSTR        = 64;
	localparam int FIELDS           = 6;
	localparam int RESET_CYCLES     = 8;
	localparam int CYCLES_PER_INSTR = 20;
	// vectors from this index on go back to back
	localparam int BURST_FIRST      = 3;

	logic     clk;
	logic     rst_n;
	logic     issue;
	opcode_e  op;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	data_t    imm;
	logic     dispatch_stall;
	logic     commit_valid;
	reg_idx_t commit_rd;
	data_t    commit_data;

	logic        mon_done;
	int          mon_errors;
	int          mon_checked;
	logic [15:0] vec [MAX_INSTR*FIELDS];
	int          num_instr     = 0;
	int          cycle_count   = 0;
	int          timeout_limit = 0;
	logic        timed_out     = 1'b0;
	integer      seed          = 32'hb6ed;

	tb_clock_gen i_clk_gen (.clk(clk));

	ooo_core i_dut
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.issue          (issue),
		.op             (op),
		.rs1            (rs1),
		.rs2            (rs2),
		.rd             (rd),
		.imm            (imm),
		.dispatch_stall (dispatch_stall),
		.commit_valid   (commit_valid),
		.commit_rd      (commit_rd),
		.commit_data    (commit_data)
	);

	ooo_monitor i_monitor
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.commit_valid  (commit_valid),
		.commit_rd     (commit_rd),
		.commit_data   (commit_data),
		.done          (mon_done),
		.error_count   (mon_errors),
		.checked_count (mon_checked)
	);

	task automatic drive_instr(input int n);
		int base;
		base  = n * FIELDS;
		op    = opcode_e'(vec[base][3:0]);
		rs1   = reg_idx_t'(vec[base+1]);
		rs2   = reg_idx_t'(vec[base+2]);
		rd    = reg_idx_t'(vec[base+3]);
		imm   = vec[base+4];
		issue = 1'b1;
	endtask

	// stall only depends on core state, so it is stable at the falling edge
	task automatic wait_accept();
		logic accepted;
		accepted = 1'b0;
		while (!accepted)
		begin
			@(negedge clk);
			accepted = !dispatch_stall;
			@(posedge clk);
			#1;
		end
		issue = 1'b0;
	endtask

	task automatic idle_gap();
		int gap;
		gap = $random(seed) & 3;
		repeat (gap)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		rst_n = 1'b0;
		issue = 1'b0;
		op    = op_add;
		rs1   = '0;
		rs2   = '0;
		rd    = '0;
		imm   = '0;
		for (int i = 0; i < MAX_INSTR * FIELDS; i++)
			vec[i] = 16'hffff;
		$readmemh("dv/ooo_vectors.txt", vec);
		while (num_instr < MAX_INSTR && vec[num_instr*FIELDS] != 16'hffff)
			num_instr++;
		timeout_limit = CYCLES_PER_INSTR * num_instr + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
		for (int n = 0; n < num_instr; n++)
		begin
			if (n < BURST_FIRST)
				idle_gap();
			drive_instr(n);
			wait_accept();
		end
	end

	always @(posedge clk)
	begin
		if (!timed_out)
		begin
			cycle_count <= cycle_count + 1;
			if (cycle_count + 1 >= timeout_limit)
				timed_out <= 1'b1;
		end
	end

	// end of run
	initial
	begin
		wait (mon_done || timed_out);
		if (!timed_out)
			repeat (4) @(posedge clk);
		if (timed_out)
			$display("timeout: %0d of %0d instructions committed after %0d cycles",
				mon_checked, num_instr, cycle_count);
		$display("commits checked: %0d, value errors: %0d, timeouts: %0d",
			mon_checked, mon_errors, timed_out);
		if (mon_errors == 0 && !timed_out)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: flist.f
+incdir+src
src/ooo_pkg.sv
src/rename_unit.sv
src/reservation_station.sv
src/exec_unit.sv
src/reorder_buffer.sv
src/ooo_core.sv
dv/tb_clock_gen.sv
dv/ooo_monitor.sv
dv/ooo_checker.sv
dv/tb_ooo_core.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_ooo_core -Mdir obj_dir
	./obj_dir/Vtb_ooo_core | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// File: dv/ooo_vectors.txt
// op rs1 rs2 rd imm expected, all hex, expected is the committed rd value
// op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 addi, 6 li
6 0 0 1 0010 0010
0 3 4 2 0000 0007
6 0 0 5 1234 1234
1 7 0 6 0000 0007
2 5 1 3 0000 0010
3 5 2 4 0000 1237
4 4 5 7 0000 0003
1 0 1 0 0000 fff0
5 0 0 0 0020 0010
5 0 0 1 0001 0011
0 1 1 1 0000 0022
6 0 0 2 00aa 00aa
4 6 5 6 0000 1233
6 0 0 3 0001 0001
6 0 0 3 0002 0002
6 0 0 3 0003 0003
0 3 3 4 0000 0006
5 5 0 5 0101 1335
5 5 0 5 0101 1436
5 5 0 5 0101 1537
5 5 0 5 0101 1638
5 5 0 5 0101 1739
5 5 0 5 0101 183a
5 5 0 5 0101 193b
5 5 0 5 0101 1a3c
5 5 0 5 0101 1b3d
5 5 0 5 0101 1c3e
5 5 0 5 0101 1d3f
5 5 0 5 0101 1e40
1 5 4 6 0000 1e3a
